/* verilog/rdma_eg_cfg_pkg.sv */
/*
 * rdma egress configuration package
 * register fields for data use and data size, their encodings,
 * and the decoded mode flags shared by the egress blocks
 */

`default_nettype none

package rdma_eg_cfg_pkg;

  // ==================================================
  // register encodings
  // ==================================================

  // operand use, code 3 falls back to mul only
  typedef enum logic [1:0] {
    duse_mul  = 2'h0,
    duse_alu  = 2'h1,
    duse_both = 2'h2,
    duse_rsvd = 2'h3
  } data_use_e;

  // element size
  typedef enum logic {
    dsize_1byte = 1'b0,
    dsize_2byte = 1'b1
  } data_size_e;

  // raw register fields, held for a whole layer
  typedef struct packed {
    data_use_e  data_use;
    data_size_e data_size;
  } eg_cfg_t;

  // decoded flags
  typedef struct packed {
    logic alu_en;
    logic mul_en;
    logic both;
    logic size_2byte;
  } eg_mode_t;

endpackage

`default_nettype wire

/* verilog/rdma_eg_data_pkg.sv */
/*
 * rdma egress data package
 * atom, read response, operand chunk and context entry layouts
 * used between the latency fifo, the context queue and the lanes
 */

`default_nettype none

package rdma_eg_data_pkg;

  // ==================================================
  // sizes
  // ==================================================
  localparam int atom_bytes    = 8;
  localparam int atoms_per_rsp = 4;
  localparam int atom_w        = atom_bytes * 8;

  typedef logic [atom_w-1:0] atom_t;

  // latency fifo payload, mask on top as on the dma side
  typedef struct packed {
    logic [atoms_per_rsp-1:0] mask;
    atom_t [atoms_per_rsp-1:0] atom;
  } rsp_t;

  // one lane entry
  // last marks the final chunk of a cube
  typedef struct packed {
    logic                      last;
    logic [atoms_per_rsp-1:0]  mask;
    atom_t [atoms_per_rsp-1:0] atom;
  } chunk_t;

  // context queue entry
  // size is total atoms minus one
  typedef struct packed {
    logic        cube_end;
    logic [14:0] size;
  } ctx_t;

endpackage

`default_nettype wire

/* verilog/rdma_eg_decode.sv */
/*
 * rdma egress decode
 * turns the register fields into mode flags, counts returned atoms
 * against the current context entry, and drives the context pop
 * and the dma credit return for each accepted response
 */

`default_nettype none

module rdma_eg_decode
  import rdma_eg_cfg_pkg::*;
  import rdma_eg_data_pkg::*;
(
  input  wire logic     nvdla_core_clk,
  input  wire logic     nvdla_core_rstn,
  input  wire eg_cfg_t  cfg,
  input  wire ctx_t     cq2eg_pd,
  input  wire logic     cq2eg_pvld,
  output logic          cq2eg_prdy,
  input  wire rsp_t     lat_fifo_rd_pd,
  input  wire logic     lat_fifo_rd_pvld,
  output logic          lat_fifo_rd_prdy,
  output logic          dma_rd_cdt_lat_fifo_pop,
  output eg_mode_t      mode,
  output rsp_t          rsp,
  output logic          rsp_vld,
  output logic          rsp_last,
  output logic          cube_end,
  input  wire logic     rsp_rdy
);

  logic        accept;
  logic [2:0]  rsp_pop;
  logic [15:0] beat_cnt;
  logic [15:0] beat_cnt_nxt;
  logic [15:0] beat_size;

  // ==================================================
  // config decode
  // ==================================================
  assign mode.both       = (cfg.data_use == duse_both);
  assign mode.alu_en     = (cfg.data_use == duse_alu) | mode.both;
  // reserved code behaves as mul only
  assign mode.mul_en     = (cfg.data_use != duse_alu);
  assign mode.size_2byte = (cfg.data_size == dsize_2byte);

  // ==================================================
  // response handoff
  // ==================================================
  // no data without its context entry
  assign rsp      = lat_fifo_rd_pd;
  assign rsp_vld  = lat_fifo_rd_pvld & cq2eg_pvld;
  assign cube_end = cq2eg_pd.cube_end;

  assign lat_fifo_rd_prdy = rsp_rdy;
  assign accept           = rsp_vld & rsp_rdy;

  // one credit back per response taken
  assign dma_rd_cdt_lat_fifo_pop = accept;

  // ==================================================
  // atom counting per context
  // ==================================================
  // atoms carried by this response
  always_comb begin
    rsp_pop = '0;
    for (int i = 0; i < atoms_per_rsp; i++) begin
      rsp_pop = rsp_pop + 3'(lat_fifo_rd_pd.mask[i]);
    end
  end

  assign beat_size    = {1'b0, cq2eg_pd.size} + 16'd1;
  assign beat_cnt_nxt = beat_cnt + 16'(rsp_pop);
  assign rsp_last     = (beat_cnt_nxt == beat_size);

  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      beat_cnt <= '0;
    end else if (accept) begin
      // restart for the next context on its final response
      if (rsp_last) begin
        beat_cnt <= '0;
      end else begin
        beat_cnt <= beat_cnt_nxt;
      end
    end
  end

  // pop the context with its final response
  assign cq2eg_prdy = accept & rsp_last;

endmodule

`default_nettype wire

/* verilog/rdma_eg_steer.sv */
/*
 * rdma egress steering
 * builds the alu and mul chunks from one response by mode,
 * interleaving bytes or words when both operands share a response,
 * and joins the two lane readies so both lanes take it together
 */

`default_nettype none

module rdma_eg_steer
  import rdma_eg_cfg_pkg::*;
  import rdma_eg_data_pkg::*;
(
  input  wire eg_mode_t mode,
  input  wire rsp_t     rsp,
  input  wire logic     rsp_vld,
  input  wire logic     rsp_last,
  input  wire logic     cube_end,
  output logic          rsp_rdy,
  output chunk_t        alu_chunk,
  output logic          alu_wr,
  input  wire logic     alu_room,
  output chunk_t        mul_chunk,
  output logic          mul_wr,
  input  wire logic     mul_room
);

  // ==================================================
  // interleave table, both mode
  // ==================================================
  // 1 byte: atom0 from bytes of atoms 0-1, atom1 from atoms 2-3
  // 2 byte: same split on 16 bit words
  // odd picks the mul half
  function automatic logic [2*atom_w-1:0] pick_half(
    input logic [atoms_per_rsp*atom_w-1:0] d,
    input logic                            odd,
    input logic                            wide
  );
    logic [2*atom_w-1:0] r;
    r = '0;
    if (wide) begin
      for (int i = 0; i < atom_w / 8; i++) begin
        r[16*i +: 16] = d[32*i + 16*odd +: 16];
      end
    end else begin
      for (int i = 0; i < atom_w / 4; i++) begin
        r[8*i +: 8] = d[16*i + 8*odd +: 8];
      end
    end
    return r;
  endfunction

  // one chunk per stream
  function automatic chunk_t build_chunk(
    input rsp_t     r,
    input eg_mode_t m,
    input logic     odd,
    input logic     last
  );
    chunk_t              c;
    logic [2*atom_w-1:0] h;
    h      = pick_half(r.atom, odd, m.size_2byte);
    c.atom = r.atom;
    c.mask = r.mask;
    c.last = last;
    if (m.both) begin
      c.atom[0] = h[atom_w-1:0];
      c.atom[1] = h[2*atom_w-1:atom_w];
      // only slots 0 and 2 feed a pair
      c.mask    = {2'b00, r.mask[2], r.mask[0]};
    end
    return c;
  endfunction

  assign alu_chunk = build_chunk(rsp, mode, 1'b0, rsp_last & cube_end);
  assign mul_chunk = build_chunk(rsp, mode, 1'b1, rsp_last & cube_end);

  // ==================================================
  // ready join and write strobes
  // ==================================================
  assign rsp_rdy = mode.both   ? (alu_room & mul_room) :
                   mode.alu_en ? alu_room : mul_room;

  // disabled lane never written
  assign alu_wr = mode.alu_en & rsp_vld & rsp_rdy;
  assign mul_wr = mode.mul_en & rsp_vld & rsp_rdy;

endmodule

`default_nettype wire

/* verilog/rdma_eg_lane.sv */
/*
 * rdma egress operand lane
 * buffers whole chunks in a small fifo and sends the head chunk out
 * one atom per cycle under valid/ready, following its mask, and
 * flags the end of a layer on the final atom of a last chunk
 */

`default_nettype none

module rdma_eg_lane
  import rdma_eg_data_pkg::*;
#(
  parameter int lane_depth = 4
) (
  input  wire logic   nvdla_core_clk,
  input  wire logic   nvdla_core_rstn,
  input  wire chunk_t chunk,
  input  wire logic   wr,
  output logic        room,
  output atom_t       pd,
  output logic        valid,
  input  wire logic   ready,
  output logic        layer_end
);

  localparam int aw = $clog2(lane_depth);

  chunk_t          mem [lane_depth];
  logic [aw:0]     wr_ptr;
  logic [aw:0]     rd_ptr;
  logic            empty;
  chunk_t          head;
  logic [1:0]      pos;
  logic [3:0]      remain;
  logic [1:0]      cur_idx;
  logic            final_atom;
  logic            xfer;
  logic            drop;
  logic            pop;

  // ==================================================
  // chunk fifo
  // ==================================================
  assign empty = (wr_ptr == rd_ptr);
  // full when wrapped once
  assign room  = !((wr_ptr[aw] != rd_ptr[aw]) && (wr_ptr[aw-1:0] == rd_ptr[aw-1:0]));

  always_ff @(posedge nvdla_core_clk) begin
    if (wr) begin
      mem[wr_ptr[aw-1:0]] <= chunk;
    end
  end

  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
    end else begin
      if (wr) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
    end
  end

  // ==================================================
  // atom serializer
  // ==================================================
  assign head   = mem[rd_ptr[aw-1:0]];
  // mask bits not yet sent
  assign remain = head.mask & (4'hf << pos);

  // lowest pending atom
  always_comb begin
    if (remain[0]) begin
      cur_idx = 2'd0;
    end else if (remain[1]) begin
      cur_idx = 2'd1;
    end else if (remain[2]) begin
      cur_idx = 2'd2;
    end else begin
      cur_idx = 2'd3;
    end
  end

  assign final_atom = ((remain & ~(4'b0001 << cur_idx)) == 4'b0000);

  assign valid = !empty && (remain != 4'b0000);
  assign pd    = head.atom[cur_idx];
  assign xfer  = valid & ready;

  // a both-mode chunk can lose all its mask bits, retire it silently
  assign drop = !empty && (remain == 4'b0000);
  assign pop  = (xfer & final_atom) | drop;

  assign layer_end = pop & head.last;

  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      pos <= '0;
    end else if (pop) begin
      pos <= '0;
    end else if (xfer) begin
      pos <= cur_idx + 2'd1;
    end
  end

endmodule

`default_nettype wire

/* verilog/rdma_eg_done.sv */
/*
 * rdma egress layer done
 * per-stream completion flags armed by op_load and set by
 * layer_end, with a registered one-cycle eg_done once both are in
 */

`default_nettype none

module rdma_eg_done
  import rdma_eg_cfg_pkg::*;
(
  input  wire logic     nvdla_core_clk,
  input  wire logic     nvdla_core_rstn,
  input  wire logic     op_load,
  input  wire eg_mode_t mode,
  input  wire logic     alu_layer_end,
  input  wire logic     mul_layer_end,
  output logic          eg_done
);

  logic alu_done;
  logic mul_done;
  logic layer_done;

  assign layer_done = alu_done & mul_done;

  // ==================================================
  // stream flags
  // ==================================================
  // idle stream counts as finished from op_load on
  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      alu_done <= 1'b0;
      mul_done <= 1'b0;
    end else if (op_load) begin
      alu_done <= !mode.alu_en;
      mul_done <= !mode.mul_en;
    end else begin
      if (alu_layer_end) begin
        alu_done <= 1'b1;
      end else if (layer_done) begin
        alu_done <= 1'b0;
      end
      if (mul_layer_end) begin
        mul_done <= 1'b1;
      end else if (layer_done) begin
        mul_done <= 1'b0;
      end
    end
  end

  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      eg_done <= 1'b0;
    end else begin
      eg_done <= layer_done;
    end
  end

endmodule

`default_nettype wire

/* verilog/rdma_eg_top.sv */
/*
 * rdma egress stage top
 * latency fifo responses in, alu and mul atom streams out,
 * with context pop, dma credit return and layer done
 */

`default_nettype none

module rdma_eg_top
  import rdma_eg_cfg_pkg::*;
  import rdma_eg_data_pkg::*;
#(
  parameter int lane_depth = 4
) (
  input  wire logic    nvdla_core_clk,
  input  wire logic    nvdla_core_rstn,
  input  wire eg_cfg_t cfg,
  input  wire logic    op_load,
  input  wire ctx_t    cq2eg_pd,
  input  wire logic    cq2eg_pvld,
  output logic         cq2eg_prdy,
  input  wire rsp_t    lat_fifo_rd_pd,
  input  wire logic    lat_fifo_rd_pvld,
  output logic         lat_fifo_rd_prdy,
  output logic         dma_rd_cdt_lat_fifo_pop,
  output atom_t        alu_pd,
  output logic         alu_valid,
  input  wire logic    alu_ready,
  output atom_t        mul_pd,
  output logic         mul_valid,
  input  wire logic    mul_ready,
  output logic         eg_done
);

  eg_mode_t mode;
  rsp_t     rsp;
  logic     rsp_vld;
  logic     rsp_last;
  logic     cube_end;
  logic     rsp_rdy;
  chunk_t   alu_chunk;
  logic     alu_wr;
  logic     alu_room;
  chunk_t   mul_chunk;
  logic     mul_wr;
  logic     mul_room;
  logic     alu_layer_end;
  logic     mul_layer_end;

  // ==================================================
  // decode and steering
  // ==================================================
  rdma_eg_decode u_decode (
    .nvdla_core_clk          (nvdla_core_clk),
    .nvdla_core_rstn         (nvdla_core_rstn),
    .cfg                     (cfg),
    .cq2eg_pd                (cq2eg_pd),
    .cq2eg_pvld              (cq2eg_pvld),
    .cq2eg_prdy              (cq2eg_prdy),
    .lat_fifo_rd_pd          (lat_fifo_rd_pd),
    .lat_fifo_rd_pvld        (lat_fifo_rd_pvld),
    .lat_fifo_rd_prdy        (lat_fifo_rd_prdy),
    .dma_rd_cdt_lat_fifo_pop (dma_rd_cdt_lat_fifo_pop),
    .mode                    (mode),
    .rsp                     (rsp),
    .rsp_vld                 (rsp_vld),
    .rsp_last                (rsp_last),
    .cube_end                (cube_end),
    .rsp_rdy                 (rsp_rdy)
  );

  rdma_eg_steer u_steer (
    .mode      (mode),
    .rsp       (rsp),
    .rsp_vld   (rsp_vld),
    .rsp_last  (rsp_last),
    .cube_end  (cube_end),
    .rsp_rdy   (rsp_rdy),
    .alu_chunk (alu_chunk),
    .alu_wr    (alu_wr),
    .alu_room  (alu_room),
    .mul_chunk (mul_chunk),
    .mul_wr    (mul_wr),
    .mul_room  (mul_room)
  );

  // ==================================================
  // operand lanes and done
  // ==================================================
  rdma_eg_lane #(.lane_depth(lane_depth)) u_alu_lane (
    .nvdla_core_clk  (nvdla_core_clk),
    .nvdla_core_rstn (nvdla_core_rstn),
    .chunk           (alu_chunk),
    .wr              (alu_wr),
    .room            (alu_room),
    .pd              (alu_pd),
    .valid           (alu_valid),
    .ready           (alu_ready),
    .layer_end       (alu_layer_end)
  );

  rdma_eg_lane #(.lane_depth(lane_depth)) u_mul_lane (
    .nvdla_core_clk  (nvdla_core_clk),
    .nvdla_core_rstn (nvdla_core_rstn),
    .chunk           (mul_chunk),
    .wr              (mul_wr),
    .room            (mul_room),
    .pd              (mul_pd),
    .valid           (mul_valid),
    .ready           (mul_ready),
    .layer_end       (mul_layer_end)
  );

  rdma_eg_done u_done (
    .nvdla_core_clk  (nvdla_core_clk),
    .nvdla_core_rstn (nvdla_core_rstn),
    .op_load         (op_load),
    .mode            (mode),
    .alu_layer_end   (alu_layer_end),
    .mul_layer_end   (mul_layer_end),
    .eg_done         (eg_done)
  );

endmodule

`default_nettype wire

/* testbench/tb_rdma_eg_model.svh */
/*
 * rdma egress reference model
 * lfsr step for stimulus and the expected steering of one
 * response into the alu and mul operand streams
 */

`ifndef TB_RDMA_EG_MODEL_SVH
`define TB_RDMA_EG_MODEL_SVH

// fibonacci lfsr, taps 32 22 2 1
function automatic logic [31:0] lfsr_next(input logic [31:0] s);
  return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
endfunction

// does an output slot carry an atom
// paired mode: slot 0 follows mask bit 0, slot 1 follows mask bit 2
function automatic logic slot_used(input logic [3:0] mask, input logic both, input int slot);
  if (!both) begin
    return mask[slot];
  end
  if (slot == 0) begin
    return mask[0];
  end
  if (slot == 1) begin
    return mask[2];
  end
  return 1'b0;
endfunction

// expected stream atom, odd picks the mul side of a pair
function automatic atom_t expect_atom(input rsp_t r, input logic both, input logic wide,
                                      input logic odd, input int slot);
  logic [127:0] pair;
  atom_t        a;
  int           k;
  if (!both) begin
    return r.atom[slot];
  end
  // two source atoms, low atom in the low half
  pair = {r.atom[2*slot+1], r.atom[2*slot]};
  a    = '0;
  for (k = 0; k < 8; k++) begin
    if (!wide) begin
      a[8*k +: 8] = 8'(pair >> (16*k + 8*int'(odd)));
    end else if (k < 4) begin
      a[16*k +: 16] = 16'(pair >> (32*k + 16*int'(odd)));
    end
  end
  return a;
endfunction

`endif

/* testbench/tb_rdma_eg.sv */
/*
 * rdma egress stage testbench
 * lfsr driven contexts and responses with random output ready,
 * checked against a reference model of steering, context pop,
 * credit return and layer done
 */

`default_nettype none

module tb_rdma_eg
  import rdma_eg_cfg_pkg::*;
  import rdma_eg_data_pkg::*;
();

  logic        nvdla_core_clk;
  logic        nvdla_core_rstn;
  eg_cfg_t     cfg;
  logic        op_load;
  ctx_t        cq2eg_pd;
  logic        cq2eg_pvld;
  logic        cq2eg_prdy;
  rsp_t        lat_fifo_rd_pd;
  logic        lat_fifo_rd_pvld;
  logic        lat_fifo_rd_prdy;
  logic        dma_rd_cdt_lat_fifo_pop;
  atom_t       alu_pd;
  logic        alu_valid;
  logic        alu_ready;
  atom_t       mul_pd;
  logic        mul_valid;
  logic        mul_ready;
  logic        eg_done;

  // stimulus queues and scoreboard
  ctx_t        ctx_q[$];
  rsp_t        rsp_q[$];
  logic        last_q[$];
  atom_t       alu_q[$];
  atom_t       mul_q[$];
  logic        hold_v[2];
  atom_t       hold_pd[2];
  logic [31:0] lfsr_state;
  logic        alu_en;
  logic        mul_en;
  logic        both;
  logic        wide;
  logic        loaded;
  logic        rsp_taken;
  string       test_name;
  int          mismatch_cnt = 0;
  int          fault_cnt = 0;
  int          rsp_sent = 0;
  int          pop_cnt = 0;
  int          done_cnt = 0;
  int          atoms_driven = 0;
  int          cycle_cnt = 0;

  `include "tb_rdma_eg_model.svh"

  rdma_eg_top #(.lane_depth(4)) uut (.*);

  always #4 nvdla_core_clk = ~nvdla_core_clk;

  // ==================================================
  // reporting
  // ==================================================
  task automatic report_mismatch(input string what, input logic [63:0] exp_v,
                                 input logic [63:0] act_v);
    mismatch_cnt++;
    $display("mismatch %s %s: expected %h actual %h", test_name, what, exp_v, act_v);
  endtask

  task automatic report_fault(input string msg);
    fault_cnt++;
    $display("error in %s at cycle %0d: %s", test_name, cycle_cnt, msg);
  endtask

  task automatic finish_run();
    $display("summary: %0d mismatches, %0d other errors, %0d responses, %0d credits, %0d done",
             mismatch_cnt, fault_cnt, rsp_sent, pop_cnt, done_cnt);
    if ((mismatch_cnt == 0) && (fault_cnt == 0)) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  endtask

  // watchdog limit grows with the atoms queued so far
  always @(posedge nvdla_core_clk) begin
    cycle_cnt = cycle_cnt + 1;
    if (cycle_cnt > 40 * atoms_driven + 1000) begin
      report_fault($sformatf("timeout, run still busy after %0d cycles", cycle_cnt));
      finish_run();
    end
  end

  // n random bits with one lfsr step per bit
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    int          i;
    v = '0;
    for (i = 0; i < n; i++) begin
      lfsr_state = lfsr_next(lfsr_state);
      v          = {v[30:0], lfsr_state[0]};
    end
    return v;
  endfunction

  // ==================================================
  // per cycle sampling and driving
  // ==================================================
  task automatic check_stream(input int s, input logic v, input logic rdy, input atom_t pd);
    atom_t exp_a;
    logic  en;
    logic  missing;
    string sname;
    en      = (s == 0) ? alu_en : mul_en;
    sname   = (s == 0) ? "alu" : "mul";
    missing = 1'b0;
    exp_a   = '0;
    if (v && !en) begin
      report_fault({sname, " valid raised on a disabled stream"});
    end
    // stalled atom must stay put
    if (hold_v[s] && !v) begin
      report_fault({sname, " valid dropped before its transfer"});
    end
    if (hold_v[s] && v && (pd != hold_pd[s])) begin
      report_mismatch({sname, " stalled data"}, hold_pd[s], pd);
    end
    hold_v[s]  = v && !rdy;
    hold_pd[s] = pd;
    if (v && rdy && en) begin
      if (s == 0) begin
        missing = (alu_q.size() == 0);
        if (!missing) begin
          exp_a = alu_q.pop_front();
        end
      end else begin
        missing = (mul_q.size() == 0);
        if (!missing) begin
          exp_a = mul_q.pop_front();
        end
      end
      if (missing) begin
        report_fault({sname, " sent an atom the model does not expect"});
      end else if (pd != exp_a) begin
        report_mismatch({sname, " atom"}, exp_a, pd);
      end
    end
  endtask

  task automatic sample_cycle();
    logic exp_last;
    rsp_taken = lat_fifo_rd_pvld && lat_fifo_rd_prdy;
    if (rsp_taken) begin
      exp_last = last_q.pop_front();
      void'(rsp_q.pop_front());
      rsp_sent++;
      if (cq2eg_prdy != exp_last) begin
        report_mismatch("context pop", 64'(exp_last), 64'(cq2eg_prdy));
      end
      if (!dma_rd_cdt_lat_fifo_pop) begin
        report_fault("no dma credit returned for an accepted response");
      end
    end else if (cq2eg_prdy || dma_rd_cdt_lat_fifo_pop) begin
      report_fault("context pop or credit return without a response transfer");
    end
    if (cq2eg_pvld && cq2eg_prdy) begin
      void'(ctx_q.pop_front());
    end
    if (dma_rd_cdt_lat_fifo_pop) begin
      pop_cnt++;
    end
    if (!loaded && (alu_valid || mul_valid || eg_done)) begin
      report_fault("output active after reset before any op_load");
    end
    check_stream(0, alu_valid, alu_ready, alu_pd);
    check_stream(1, mul_valid, mul_ready, mul_pd);
    if (eg_done) begin
      done_cnt++;
      if ((alu_q.size() != 0) || (mul_q.size() != 0) || (rsp_q.size() != 0)) begin
        report_fault("eg_done raised before the layer drained");
      end
    end
  endtask

  task automatic drive_cycle();
    cq2eg_pvld = (ctx_q.size() > 0);
    if (cq2eg_pvld) begin
      cq2eg_pd = ctx_q[0];
    end
    // raised response valid holds until taken
    if (!lat_fifo_rd_pvld || rsp_taken) begin
      lat_fifo_rd_pvld = (rsp_q.size() > 0) && cq2eg_pvld && (rand_bits(2) != 0);
    end
    if (lat_fifo_rd_pvld) begin
      lat_fifo_rd_pd = rsp_q[0];
    end
    alu_ready = (rand_bits(2) != 0);
    mul_ready = (rand_bits(2) != 0);
  endtask

  // outputs sampled mid cycle and inputs driven just after the edge
  task automatic step();
    @(negedge nvdla_core_clk);
    sample_cycle();
    @(posedge nvdla_core_clk);
    #1;
    drive_cycle();
  endtask

  // ==================================================
  // layer stimulus
  // ==================================================
  task automatic push_expected(input rsp_t r);
    int slot;
    for (slot = 0; slot < 4; slot++) begin
      if (slot_used(r.mask, both, slot)) begin
        if (alu_en) begin
          alu_q.push_back(expect_atom(r, both, wide, 1'b0, slot));
        end
        if (mul_en) begin
          mul_q.push_back(expect_atom(r, both, wide, 1'b1, slot));
        end
      end
    end
  endtask

  // 1 to 3 contexts with cube_end on the last one
  task automatic gen_layer();
    int         n_ctx;
    int         ci;
    int         a;
    int         left;
    ctx_t       c;
    rsp_t       r;
    logic [3:0] m;
    n_ctx = 1 + int'(rand_bits(2) % 3);
    for (ci = 0; ci < n_ctx; ci++) begin
      left       = 1 + int'(rand_bits(4));
      c.size     = 15'(left - 1);
      c.cube_end = (ci == n_ctx - 1);
      ctx_q.push_back(c);
      atoms_driven += left;
      // masks whose populations add up to the context size
      while (left > 0) begin
        m = 4'(rand_bits(4));
        if ((m != 4'b0000) && ($countones(m) <= left)) begin
          for (a = 0; a < 4; a++) begin
            r.atom[a] = {rand_bits(32), rand_bits(32)};
          end
          r.mask = m;
          left   = left - $countones(m);
          rsp_q.push_back(r);
          last_q.push_back(left == 0);
          push_expected(r);
        end
      end
    end
  endtask

  task automatic run_layer(input int use_code, input int size_code, input int layer);
    int done_before;
    test_name     = $sformatf("use%0d_size%0d_layer%0d", use_code, size_code, layer);
    cfg.data_use  = data_use_e'(2'(use_code));
    cfg.data_size = data_size_e'(1'(size_code));
    alu_en        = (use_code == 1) || (use_code == 2);
    mul_en        = (use_code != 1);
    both          = (use_code == 2);
    wide          = (size_code == 1);
    // a pulse left over from the last layer counts against this one
    done_before   = done_cnt;
    op_load       = 1'b1;
    loaded        = 1'b1;
    step();
    op_load = 1'b0;
    gen_layer();
    while (done_cnt == done_before) begin
      step();
    end
    // a few idle cycles to catch a second pulse
    repeat (4) step();
    if (done_cnt != done_before + 1) begin
      report_mismatch("eg_done pulses", 64'(done_before + 1), 64'(done_cnt));
    end
    if ((alu_q.size() + mul_q.size() + rsp_q.size() + ctx_q.size()) != 0) begin
      report_fault("stimulus or expected atoms left over after the layer");
    end
  endtask

  // ==================================================
  // main flow
  // ==================================================
  initial begin
    int u;
    int z;
    int l;
    nvdla_core_clk   = 1'b0;
    nvdla_core_rstn  = 1'b0;
    cfg              = '0;
    op_load          = 1'b0;
    cq2eg_pd         = '0;
    cq2eg_pvld       = 1'b0;
    lat_fifo_rd_pd   = '0;
    lat_fifo_rd_pvld = 1'b0;
    alu_ready        = 1'b0;
    mul_ready        = 1'b0;
    hold_v[0]        = 1'b0;
    hold_v[1]        = 1'b0;
    alu_en           = 1'b0;
    mul_en           = 1'b1;
    both             = 1'b0;
    wide             = 1'b0;
    loaded           = 1'b0;
    rsp_taken        = 1'b0;
    lfsr_state       = 32'h9749_73dd;
    test_name        = "reset";
    repeat (8) @(posedge nvdla_core_clk);
    #1;
    nvdla_core_rstn = 1'b1;
    // quiet outputs until the first op_load
    repeat (6) step();
    for (u = 0; u < 3; u++) begin
      for (z = 0; z < 2; z++) begin
        for (l = 0; l < 3; l++) begin
          run_layer(u, z, l);
        end
      end
    end
    test_name = "final";
    if (pop_cnt != rsp_sent) begin
      report_mismatch("credit pops", 64'(rsp_sent), 64'(pop_cnt));
    end
    finish_run();
  end

endmodule

`default_nettype wire

/* compile.f */
+incdir+testbench
verilog/rdma_eg_cfg_pkg.sv
verilog/rdma_eg_data_pkg.sv
verilog/rdma_eg_decode.sv
verilog/rdma_eg_steer.sv
verilog/rdma_eg_lane.sv
verilog/rdma_eg_done.sv
verilog/rdma_eg_top.sv
testbench/tb_rdma_eg.sv

/* run_sim.sh */
#!/bin/sh
# build the rdma egress testbench with verilator, run it, then check the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log build.log
verilator --binary --timing -Wno-fatal --top-module tb_rdma_eg -f compile.f -o tb_rdma_eg \
  > build.log 2>&1 \
  && ./obj_dir/tb_rdma_eg > sim.log 2>&1 \
  || { echo "build or simulation error, see build.log and sim.log"; exit 1; }
grep -q "Simulation completed successfully" sim.log \
  && echo "PASS" \
  || { echo "FAIL, see sim.log"; exit 1; }
